//--- Makefile
TOP = cp0_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f cp0.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- cp0.f
source/cp0_reg_pkg.sv
source/cp0_exc_pkg.sv
source/cp0_access_port.sv
source/cp0_timer.sv
source/cp0_regs.sv
source/cp0.sv
verification/cp0_tb.sv

//--- source/cp0.sv
`timescale 1ns/1ps
`default_nettype none

module cp0 (
    input  wire                          cp0_clk,
    input  wire                          reset,
    input  wire cp0_reg_pkg::mtc0_req_t  slot1,
    input  wire cp0_reg_pkg::mtc0_req_t  slot2,
    input  wire cp0_exc_pkg::cp0_event_t exc,
    input  wire cp0_reg_pkg::ext_int_t   ext_int,
    output cp0_reg_pkg::cp0_word_t       rdata1,
    output cp0_reg_pkg::cp0_word_t       rdata2,
    output logic                         has_int,
    output cp0_reg_pkg::cp0_word_t       epc,
    output cp0_reg_pkg::status_t         status,
    output cp0_reg_pkg::cause_t          cause
);
    import cp0_reg_pkg::*;

    mtc0_req_t  req   [N_SLOTS];
    cp0_wsel_t  wsel  [N_SLOTS];
    cp0_word_t  wdata [N_SLOTS];
    cp0_word_t  rdata [N_SLOTS];
    cp0_state_t state;

    // Slot 2 is the later instruction
    assign req[0] = slot1;
    assign req[1] = slot2;

    for (genvar i = 0; i < N_SLOTS; i++) begin : g_slot
        assign wdata[i] = req[i].wdata;

        cp0_access_port port_inst (
            .cp0_clk (cp0_clk),
            .reset   (reset),
            .req     (req[i]),
            .state   (state),
            .wsel    (wsel[i]),
            .rdata   (rdata[i])
        );
    end

    cp0_regs regs_inst (
        .cp0_clk (cp0_clk),
        .reset   (reset),
        .wsel    (wsel),
        .wdata   (wdata),
        .exc     (exc),
        .ext_int (ext_int),
        .state   (state),
        .has_int (has_int)
    );

    assign rdata1 = rdata[0];
    assign rdata2 = rdata[1];
    assign epc    = state.epc;
    assign status = state.status;
    assign cause  = state.cause;

endmodule

`default_nettype wire

//--- source/cp0_access_port.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_access_port (
    input  wire                          cp0_clk,
    input  wire                          reset,
    input  wire cp0_reg_pkg::mtc0_req_t  req,
    input  wire cp0_reg_pkg::cp0_state_t state,
    output cp0_reg_pkg::cp0_wsel_t       wsel,
    output cp0_reg_pkg::cp0_word_t       rdata
);
    import cp0_reg_pkg::*;

    cp0_wsel_t hit;

    always_comb begin
        hit   = '0;
        rdata = '0;
        case (req.addr)
            CR_STATUS: begin
                hit[REG_STATUS] = 1'b1;
                rdata           = state.status;
            end
            CR_CAUSE: begin
                hit[REG_CAUSE] = 1'b1;
                rdata          = state.cause;
            end
            CR_EPC: begin
                hit[REG_EPC] = 1'b1;
                rdata        = state.epc;
            end
            CR_COUNT: begin
                hit[REG_COUNT] = 1'b1;
                rdata          = state.count;
            end
            CR_COMPARE: begin
                hit[REG_COMPARE] = 1'b1;
                rdata            = state.compare;
            end
            CR_BADVADDR: begin
                hit[REG_BADVADDR] = 1'b1;
                rdata             = state.badvaddr;
            end
            // Unmapped addresses read zero
            default: begin
                hit   = '0;
                rdata = '0;
            end
        endcase
    end

    assign wsel = req.we ? hit : '0;

    assert property (@(posedge cp0_clk) disable iff (reset) $onehot0(wsel))
        else $error("cp0_access_port: multi-hot write select %b", wsel);

endmodule

`default_nettype wire

//--- source/cp0_exc_pkg.sv
`default_nettype none

package cp0_exc_pkg;

    typedef logic [4:0] exc_code_t;

    // Address-related exceptions
    localparam exc_code_t EXC_MOD  = 5'd1;
    localparam exc_code_t EXC_TLBL = 5'd2;
    localparam exc_code_t EXC_TLBS = 5'd3;
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_ADES = 5'd5;

    // One bit per ExcCode, set where BadVAddr is loaded
    localparam logic [31:0] BADVADDR_CODES = (32'd1 << EXC_MOD)
                                           | (32'd1 << EXC_TLBL)
                                           | (32'd1 << EXC_TLBS)
                                           | (32'd1 << EXC_ADEL)
                                           | (32'd1 << EXC_ADES);

    typedef struct packed {
        logic        ex;
        exc_code_t   code;
        logic        bd;
        logic [1:0]  ce;
        logic [31:0] pc;
        logic [31:0] badvaddr;
        logic        eret;
    } cp0_event_t;

endpackage

`default_nettype wire

//--- source/cp0_reg_pkg.sv
`default_nettype none

package cp0_reg_pkg;

    typedef logic [7:0]  cp0_addr_t;
    typedef logic [31:0] cp0_word_t;
    typedef logic [7:0]  int_vec_t;
    typedef logic [5:0]  ext_int_t;

    // Address is {rd, sel}
    localparam cp0_addr_t CR_STATUS   = 8'b01100_000;
    localparam cp0_addr_t CR_CAUSE    = 8'b01101_000;
    localparam cp0_addr_t CR_EPC      = 8'b01110_000;
    localparam cp0_addr_t CR_COUNT    = 8'b01001_000;
    localparam cp0_addr_t CR_COMPARE  = 8'b01011_000;
    localparam cp0_addr_t CR_BADVADDR = 8'b01000_000;

    localparam int N_SLOTS = 2;
    localparam int N_REGS  = 6;

    // Bit positions in the write-select vector
    typedef enum logic [2:0] {
        REG_STATUS,
        REG_CAUSE,
        REG_EPC,
        REG_COUNT,
        REG_COMPARE,
        REG_BADVADDR
    } cp0_reg_e;

    typedef logic [N_REGS-1:0] cp0_wsel_t;

    typedef struct packed {
        logic      we;
        cp0_addr_t addr;
        cp0_word_t wdata;
    } mtc0_req_t;

    typedef struct packed {
        logic [2:0] zero_31_29;
        logic       cu0;
        logic [4:0] zero_27_23;
        logic       bev;
        logic [5:0] zero_21_16;
        int_vec_t   im;
        logic [2:0] zero_7_5;
        logic       um;
        logic [1:0] zero_3_2;
        logic       exl;
        logic       ie;
    } status_t;

    typedef struct packed {
        logic       bd;
        logic       ti;
        logic [1:0] ce;
        logic [3:0] zero_27_24;
        logic       iv;
        logic [6:0] zero_22_16;
        int_vec_t   ip;
        logic       zero_7;
        logic [4:0] exc_code;
        logic [1:0] zero_1_0;
    } cause_t;

    typedef struct packed {
        status_t   status;
        cause_t    cause;
        cp0_word_t epc;
        cp0_word_t badvaddr;
        cp0_word_t count;
        cp0_word_t compare;
    } cp0_state_t;

    typedef struct packed {
        cp0_wsel_t wsel;
        cp0_word_t wdata;
    } cp0_wr_t;

endpackage

`default_nettype wire

//--- source/cp0_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_regs (
    input  wire                          cp0_clk,
    input  wire                          reset,
    input  wire cp0_reg_pkg::cp0_wsel_t  wsel  [cp0_reg_pkg::N_SLOTS],
    input  wire cp0_reg_pkg::cp0_word_t  wdata [cp0_reg_pkg::N_SLOTS],
    input  wire cp0_exc_pkg::cp0_event_t exc,
    input  wire cp0_reg_pkg::ext_int_t   ext_int,
    output cp0_reg_pkg::cp0_state_t      state,
    output logic                         has_int
);
    import cp0_reg_pkg::*;
    import cp0_exc_pkg::*;

    status_t   status_q;
    cause_t    cause_q;
    cp0_word_t epc_q;
    cp0_word_t badvaddr_q;
    cp0_wsel_t wr_any;
    cp0_wr_t   timer_wr;
    cp0_word_t count;
    cp0_word_t compare;
    logic      ti;
    status_t   status_wdata;
    cause_t    cause_wdata;
    cp0_word_t epc_wdata;

    // Later slot wins, so slot 2 overrides slot 1
    function automatic cp0_word_t slot_data(input cp0_reg_e r);
        cp0_word_t d;
        d = '0;
        for (int s = 0; s < N_SLOTS; s++) begin
            if (wsel[s][r]) begin
                d = wdata[s];
            end
        end
        return d;
    endfunction

    always_comb begin
        wr_any = '0;
        for (int s = 0; s < N_SLOTS; s++) begin
            wr_any = wr_any | wsel[s];
        end
    end

    assign status_wdata = status_t'(slot_data(REG_STATUS));
    assign cause_wdata  = cause_t'(slot_data(REG_CAUSE));
    assign epc_wdata    = slot_data(REG_EPC);

    // Count and Compare share one data word, the latest timer write takes it
    always_comb begin
        timer_wr = '0;
        for (int s = 0; s < N_SLOTS; s++) begin
            if (wsel[s][REG_COUNT] || wsel[s][REG_COMPARE]) begin
                timer_wr.wsel  = wsel[s];
                timer_wr.wdata = wdata[s];
            end
        end
    end

    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            status_q     <= '0;
            status_q.bev <= 1'b1;
        end else begin
            if (wr_any[REG_STATUS]) begin
                status_q.cu0 <= status_wdata.cu0;
                status_q.bev <= status_wdata.bev;
                status_q.im  <= status_wdata.im;
                status_q.um  <= status_wdata.um;
                status_q.ie  <= status_wdata.ie;
            end
            if (exc.ex) begin
                status_q.exl <= 1'b1;
            end else if (exc.eret) begin
                status_q.exl <= 1'b0;
            end else if (wr_any[REG_STATUS]) begin
                status_q.exl <= status_wdata.exl;
            end
        end
    end

    // TI lives in the timer and is merged on read
    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            cause_q <= '0;
        end else begin
            cause_q.ip[7]   <= ext_int[5] | ti;
            cause_q.ip[6:2] <= ext_int[4:0];
            if (wr_any[REG_CAUSE]) begin
                cause_q.iv      <= cause_wdata.iv;
                cause_q.ip[1:0] <= cause_wdata.ip[1:0];
            end
            if (exc.ex) begin
                cause_q.ce       <= exc.ce;
                cause_q.exc_code <= exc.code;
                if (!status_q.exl) begin
                    cause_q.bd <= exc.bd;
                end
            end
        end
    end

    // Nested exceptions keep the first return address
    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            epc_q <= '0;
        end else if (exc.ex && !status_q.exl) begin
            epc_q <= exc.bd ? exc.pc - 32'd4 : exc.pc;
        end else if (wr_any[REG_EPC]) begin
            epc_q <= epc_wdata;
        end
    end

    // Read-only from software
    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            badvaddr_q <= '0;
        end else if (exc.ex && BADVADDR_CODES[exc.code]) begin
            badvaddr_q <= exc.badvaddr;
        end
    end

    cp0_timer timer_inst (
        .cp0_clk (cp0_clk),
        .reset   (reset),
        .wr      (timer_wr),
        .count   (count),
        .compare (compare),
        .ti      (ti)
    );

    always_comb begin
        state          = '0;
        state.status   = status_q;
        state.cause    = cause_q;
        state.cause.ti = ti;
        state.epc      = epc_q;
        state.badvaddr = badvaddr_q;
        state.count    = count;
        state.compare  = compare;
    end

    assign has_int = (|(cause_q.ip & status_q.im)) && status_q.ie && !status_q.exl;

    assert property (@(posedge cp0_clk) disable iff (reset) !(exc.ex && exc.eret))
        else $error("cp0_regs: exception and eret in the same cycle");

endmodule

`default_nettype wire

//--- source/cp0_timer.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_timer (
    input  wire                       cp0_clk,
    input  wire                       reset,
    input  wire cp0_reg_pkg::cp0_wr_t wr,
    output cp0_reg_pkg::cp0_word_t    count,
    output cp0_reg_pkg::cp0_word_t    compare,
    output logic                      ti
);
    import cp0_reg_pkg::*;

    logic      tick;
    logic      count_hit;
    cp0_word_t count_q;
    cp0_word_t compare_q;

    // Count runs at half the core clock
    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            tick <= 1'b0;
        end else begin
            tick <= ~tick;
        end
    end

    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            count_q <= '0;
        end else if (wr.wsel[REG_COUNT]) begin
            count_q <= wr.wdata;
        end else if (tick) begin
            count_q <= count_q + 32'd1;
        end
    end

    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            compare_q <= '0;
        end else if (wr.wsel[REG_COMPARE]) begin
            compare_q <= wr.wdata;
        end
    end

    // Zero compare never fires
    assign count_hit = (count_q == compare_q) && (compare_q != '0);

    always_ff @(posedge cp0_clk) begin
        if (reset) begin
            ti <= 1'b0;
        end else if (wr.wsel[REG_COMPARE]) begin
            ti <= 1'b0;
        end else if (count_hit) begin
            ti <= 1'b1;
        end
    end

    assign count   = count_q;
    assign compare = compare_q;

    assert property (@(posedge cp0_clk) disable iff (reset) wr.wsel[REG_COMPARE] |=> !ti)
        else $error("cp0_timer: TI set right after a Compare write");

endmodule

`default_nettype wire

//--- verification/cp0_input.txt
# s1_we s1_addr s1_wdata s2_we s2_addr s2_wdata ex code bd ce pc badvaddr eret ext_int
#   mask exp_rdata1 exp_rdata2 exp_has_int exp_epc (hex; mask 1 rdata1 2 rdata2 4 has_int 8 epc)
0 60 00000000 0 60 00000000 0 00 0 0 00000000 00000000 0 00 f 00400000 00400000 0 00000000
1 60 ffffffff 0 60 00000000 0 00 0 0 00000000 00000000 0 00 f 00400000 00400000 0 00000000
0 60 00000000 0 60 00000000 0 00 0 0 00000000 00000000 0 00 f 1040ff13 1040ff13 0 00000000
1 70 12345678 0 70 00000000 0 00 0 0 00000000 00000000 0 00 f 00000000 00000000 0 00000000
1 70 aaaa0000 1 70 bbbb0004 0 00 0 0 00000000 00000000 0 00 f 12345678 12345678 0 12345678
0 70 00000000 0 70 00000000 0 00 0 0 00000000 00000000 0 00 f bbbb0004 bbbb0004 0 bbbb0004
0 68 00000000 1 68 ffffffff 0 00 0 0 00000000 00000000 0 00 f 00000000 00000000 0 bbbb0004
0 68 00000000 0 68 00000000 0 00 0 0 00000000 00000000 0 00 f 00800300 00800300 0 bbbb0004
1 60 0000ff01 0 60 00000000 0 00 0 0 00000000 00000000 0 00 f 1040ff13 1040ff13 0 bbbb0004
0 60 00000000 0 60 00000000 0 00 0 0 00000000 00000000 0 00 f 0000ff01 0000ff01 1 bbbb0004
1 68 00000000 0 68 00000000 0 00 0 0 00000000 00000000 0 00 f 00800300 00800300 1 bbbb0004
0 68 00000000 0 68 00000000 0 00 0 0 00000000 00000000 0 00 f 00000000 00000000 0 bbbb0004
0 68 00000000 0 68 00000000 0 00 0 0 00000000 00000000 0 01 f 00000000 00000000 0 bbbb0004
0 68 00000000 0 68 00000000 0 00 0 0 00000000 00000000 0 01 f 00000400 00000400 1 bbbb0004
1 60 0000ff00 0 68 00000000 0 00 0 0 00000000 00000000 0 01 f 0000ff01 00000400 1 bbbb0004
0 60 00000000 0 68 00000000 0 00 0 0 00000000 00000000 0 01 f 0000ff00 00000400 0 bbbb0004
1 60 0000ff01 0 78 00000000 0 00 0 0 00000000 00000000 0 01 f 0000ff00 00000000 0 bbbb0004
0 60 00000000 0 68 00000000 0 00 0 0 00000000 00000000 0 01 f 0000ff01 00000400 1 bbbb0004
0 70 00000000 0 40 00000000 1 04 1 2 80001004 deadbee1 0 00 f bbbb0004 00000000 1 bbbb0004
0 70 00000000 0 40 00000000 0 00 0 0 00000000 00000000 0 00 f 80001000 deadbee1 0 80001000
0 60 00000000 0 68 00000000 0 00 0 0 00000000 00000000 0 00 f 0000ff03 a0000010 0 80001000
0 70 00000000 0 68 00000000 1 08 0 1 80002000 11111111 0 01 f 80001000 a0000010 0 80001000
0 70 00000000 0 40 00000000 0 00 0 0 00000000 00000000 0 01 f 80001000 deadbee1 0 80001000
0 68 00000000 0 60 00000000 0 00 0 0 00000000 00000000 0 01 f 90000420 0000ff03 0 80001000
0 60 00000000 0 68 00000000 0 00 0 0 00000000 00000000 1 01 f 0000ff03 90000420 0 80001000
0 60 00000000 0 70 00000000 0 00 0 0 00000000 00000000 0 00 f 0000ff01 80001000 1 80001000
0 68 00000000 0 60 00000000 0 00 0 0 00000000 00000000 0 00 f 90000020 0000ff01 0 80001000
1 48 00000100 0 48 00000000 0 00 0 0 00000000 00000000 0 00 f 0000000d 0000000d 0 80001000
0 48 00000000 0 48 00000000 0 00 0 0 00000000 00000000 0 00 f 00000100 00000100 0 80001000
0 48 00000000 0 48 00000000 0 00 0 0 00000000 00000000 0 00 f 00000100 00000100 0 80001000
0 48 00000000 0 58 00000000 0 00 0 0 00000000 00000000 0 00 f 00000101 00000000 0 80001000
0 48 00000000 1 58 00000104 0 00 0 0 00000000 00000000 0 00 f 00000101 00000000 0 80001000
0 58 00000000 0 48 00000000 0 00 0 0 00000000 00000000 0 00 f 00000104 00000102 0 80001000
0 48 00000000 0 48 00000000 0 00 0 0 00000000 00000000 0 00 f 00000102 00000102 0 80001000
0 48 00000000 0 48 00000000 0 00 0 0 00000000 00000000 0 00 f 00000103 00000103 0 80001000
0 48 00000000 0 48 00000000 0 00 0 0 00000000 00000000 0 00 f 00000103 00000103 0 80001000
0 48 00000000 0 68 00000000 0 00 0 0 00000000 00000000 0 00 f 00000104 90000020 0 80001000
0 68 00000000 0 48 00000000 0 00 0 0 00000000 00000000 0 00 f d0000020 00000104 0 80001000
0 68 00000000 0 48 00000000 0 00 0 0 00000000 00000000 0 00 f d0008020 00000105 1 80001000
0 68 00000000 1 58 00000200 0 00 0 0 00000000 00000000 0 00 f d0008020 00000104 1 80001000
0 68 00000000 0 58 00000000 0 00 0 0 00000000 00000000 0 00 f 90008020 00000200 1 80001000
0 68 00000000 0 48 00000000 0 00 0 0 00000000 00000000 0 00 f 90000020 00000106 0 80001000

//--- verification/cp0_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_tb;
    import cp0_reg_pkg::*;
    import cp0_exc_pkg::*;

    localparam int    N_FIELDS = 19;
    localparam string VEC_FILE = "verification/cp0_input.txt";

    // One stimulus line with the outputs expected in that cycle
    typedef struct packed {
        mtc0_req_t  slot1;
        mtc0_req_t  slot2;
        cp0_event_t exc;
        ext_int_t   ext_int;
        logic [3:0] mask;
        cp0_word_t  rdata1;
        cp0_word_t  rdata2;
        logic       has_int;
        cp0_word_t  epc;
    } vector_t;

    logic       cp0_clk;
    logic       reset;
    mtc0_req_t  slot1;
    mtc0_req_t  slot2;
    cp0_event_t exc;
    ext_int_t   ext_int;
    cp0_word_t  rdata1;
    cp0_word_t  rdata2;
    logic       has_int;
    cp0_word_t  epc;
    status_t    status;
    cause_t     cause;

    vector_t vectors[$];
    logic    vectors_loaded;

    cp0 cp0_inst (
        .cp0_clk (cp0_clk),
        .reset   (reset),
        .slot1   (slot1),
        .slot2   (slot2),
        .exc     (exc),
        .ext_int (ext_int),
        .rdata1  (rdata1),
        .rdata2  (rdata2),
        .has_int (has_int),
        .epc     (epc),
        .status  (status),
        .cause   (cause)
    );

    always #50 cp0_clk = ~cp0_clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic check_word(input string name, input cp0_word_t expected,
                              input cp0_word_t actual);
        assert (actual === expected) else begin
            fail_run($sformatf("FAILED time=%0t signal=%s expected=%h actual=%h",
                               $time, name, expected, actual));
        end
    endtask

    // Raw status and cause words equal what a port reads at that address
    task automatic compare_raw_output(input cp0_addr_t addr, input cp0_word_t expected);
        if (addr == CR_STATUS) begin
            check_word("status", expected, status);
        end else if (addr == CR_CAUSE) begin
            check_word("cause", expected, cause);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [N_FIELDS];
        vector_t     v;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            fail_run({"cannot open the stimulus file ", VEC_FILE});
        end
        while ($fgets(line, fd) > 0) begin
            // Skip blank lines and the column header
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
            if (n != N_FIELDS) begin
                fail_run({"malformed line in the stimulus file: ", line});
            end
            v.slot1.we      = f[0][0];
            v.slot1.addr    = f[1][7:0];
            v.slot1.wdata   = f[2];
            v.slot2.we      = f[3][0];
            v.slot2.addr    = f[4][7:0];
            v.slot2.wdata   = f[5];
            v.exc.ex        = f[6][0];
            v.exc.code      = f[7][4:0];
            v.exc.bd        = f[8][0];
            v.exc.ce        = f[9][1:0];
            v.exc.pc        = f[10];
            v.exc.badvaddr  = f[11];
            v.exc.eret      = f[12][0];
            v.ext_int       = f[13][5:0];
            v.mask          = f[14][3:0];
            v.rdata1        = f[15];
            v.rdata2        = f[16];
            v.has_int       = f[17][0];
            v.epc           = f[18];
            vectors.push_back(v);
        end
        $fclose(fd);
    endtask

    task automatic drive_vector(input vector_t v);
        slot1   = v.slot1;
        slot2   = v.slot2;
        exc     = v.exc;
        ext_int = v.ext_int;
    endtask

    // Mask bits select rdata1, rdata2, has_int and epc
    task automatic check_vector(input vector_t v);
        if (v.mask[0]) begin
            check_word("rdata1", v.rdata1, rdata1);
            compare_raw_output(v.slot1.addr, v.rdata1);
        end
        if (v.mask[1]) begin
            check_word("rdata2", v.rdata2, rdata2);
            compare_raw_output(v.slot2.addr, v.rdata2);
        end
        if (v.mask[2]) begin
            check_word("has_int", {31'b0, v.has_int}, {31'b0, has_int});
        end
        if (v.mask[3]) begin
            check_word("epc", v.epc, epc);
        end
    endtask

    initial begin
        cp0_clk        = 1'b0;
        reset          = 1'b1;
        slot1          = '0;
        slot2          = '0;
        exc            = '0;
        ext_int        = '0;
        vectors_loaded = 1'b0;
        load_vectors();
        if (vectors.size() == 0) begin
            fail_run("the stimulus file holds no vectors");
        end
        vectors_loaded = 1'b1;
        repeat (8) begin
            @(posedge cp0_clk);
        end
        #5;
        reset = 1'b0;
        foreach (vectors[i]) begin
            drive_vector(vectors[i]);
            // Sample just before the next rising edge
            #90;
            check_vector(vectors[i]);
            @(posedge cp0_clk);
            #5;
        end
        $display("Test OK");
        $finish;
    end

    initial begin
        int timeout_ns;
        wait (vectors_loaded === 1'b1);
        timeout_ns = vectors.size() * 100 + 2000;
        #(timeout_ns);
        fail_run("watchdog expired before all vectors were applied");
    end

endmodule

`default_nettype wire
